// File: escape_parser.sv
`timescale 1ns/100ps
`include "host_link_config.svh"

module escape_parser (
    input  logic                   iCLK,
    input  logic                   iRST,
    input  logic                   byte_valid,
    input  host_proto_pkg::byte_t  byte_data,
    input  logic                   cmd_mode,
    input  logic                   instr_ack,
    input  logic                   data_ack,
    output host_proto_pkg::token_t token
);
    import host_proto_pkg::*;

    logic      esc_armed;
    logic      dec_instr;
    logic      dec_data;
    instr_e    dec_kind;
    host_cmd_e dec_cmd;

    // ==================================================
    // byte decode
    // ==================================================
    always_comb begin
        dec_instr = 1'b0;
        dec_data  = 1'b0;
        dec_kind  = INSTR_BAD;
        dec_cmd   = host_cmd_e'(byte_data);
        if (esc_armed) begin
            case (byte_data)
                ESC_IDLE: begin
                    dec_instr = 1'b1;
                    dec_kind  = INSTR_IDLE;
                end
                ESC_ACK: begin
                    dec_instr = 1'b1;
                    dec_kind  = INSTR_ACK;
                end
                // doubled escape is a literal 0xFE payload byte
                ESC_LITERAL: dec_data = 1'b1;
                default:     dec_instr = 1'b1;
            endcase
        end else if (byte_data == `ESC_BYTE) begin
            // only arms escape mode
            dec_instr = 1'b0;
        end else if (cmd_mode) begin
            dec_instr = 1'b1;
            case (byte_data)
                CMD_OFFSET_H, CMD_OFFSET_V, CMD_CYCLES,
                CMD_TRIGGER, CMD_GALVO_X, CMD_GALVO_Y: dec_kind = INSTR_CMD;
                default: dec_kind = INSTR_BAD;
            endcase
        end else begin
            dec_data = 1'b1;
        end
    end

    // ==================================================
    // pending token, held until the fsm acknowledges
    // ==================================================
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            esc_armed <= 1'b0;
            token     <= '0;
        end else begin
            if (instr_ack) begin
                token.instr_pending <= 1'b0;
            end
            if (data_ack) begin
                token.data_pending <= 1'b0;
            end
            if (byte_valid) begin
                esc_armed <= !esc_armed && (byte_data == `ESC_BYTE);
                // a newer token replaces whatever is still pending
                if (dec_instr) begin
                    token.instr_pending <= 1'b1;
                    token.data_pending  <= 1'b0;
                    token.instr         <= dec_kind;
                    token.cmd           <= dec_cmd;
                end else if (dec_data) begin
                    token.data_pending  <= 1'b1;
                    token.instr_pending <= 1'b0;
                    token.data          <= byte_data;
                end
            end
        end
    end

    a_one_token_kind: assert property (@(posedge iCLK) disable iff (iRST)
        !($rose(token.instr_pending) && $rose(token.data_pending)))
        else $error("instruction and data raised together");

endmodule

// File: field_byte_counter.sv
`timescale 1ns/100ps

module field_byte_counter (
    input  logic       iCLK,
    input  logic       iRST,
    input  logic       start,
    input  logic [1:0] length,
    input  logic       step,
    output logic [1:0] index,
    output logic       last
);

    logic [1:0] len_q;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            len_q <= 2'd0;
            index <= 2'd0;
        end else if (start) begin
            len_q <= length;
            index <= 2'd0;
        end else if (step) begin
            index <= index + 2'd1;
        end
    end

    // final byte of the field
    assign last = (index == len_q - 2'd1);

    a_step_in_range: assert property (@(posedge iCLK) disable iff (iRST)
        step |-> (index < len_q))
        else $error("byte step beyond field length");

endmodule

// File: host_ctrl_pkg.sv
`include "host_link_config.svh"

package host_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ERROR,
        ST_COLLECT,
        ST_SEQ_TRIGGER,
        ST_WAIT_ACK
    } ctrl_state_e;

    // register targeted by a multi-byte command
    typedef enum logic [2:0] {
        FLD_OFFSET_H,
        FLD_OFFSET_V,
        FLD_CYCLES,
        FLD_GALVO_X,
        FLD_GALVO_Y
    } field_e;

    typedef struct packed {
        logic               valid;
        field_e             field;
        logic [1:0]         index;
        logic [`BYTE_W-1:0] data;
    } field_wr_t;

    typedef struct packed {
        logic                h_sign;
        logic [`BYTE_W-1:0]  h_offset;
        logic                v_sign;
        logic [`BYTE_W-1:0]  v_offset;
        logic [`CYC_W-1:0]   cycles;
        logic [`GALVO_W-1:0] galvo_x;
        logic [`GALVO_W-1:0] galvo_y;
    } settings_t;

endpackage

// File: host_link_config.svh
`ifndef HOST_LINK_CONFIG_SVH
`define HOST_LINK_CONFIG_SVH

// ==================================================
// host link widths and protocol constants
// ==================================================

`define BYTE_W       8

// escape character on the host stream
`define ESC_BYTE     8'hFE

// offset magnitude reported once its top bit is set
`define OFFSET_CLAMP 128

`define CYC_W        16
`define GALVO_W      24

`endif

// File: host_link_decode.f
+incdir+.
host_proto_pkg.sv
host_ctrl_pkg.sv
jtag_uart_reader.sv
escape_parser.sv
field_byte_counter.sv
link_fsm.sv
settings_regs.sv
host_link_decode.sv
tb_host_link_decode.sv

// File: host_link_decode.sv
`timescale 1ns/100ps

module host_link_decode (
    input  logic                       iCLK,
    input  logic                       iRST,
    input  logic [31:0]                jtag_rddata,
    input  logic                       jtag_wait,
    output logic                       jtag_rdreq,
    output host_ctrl_pkg::settings_t   settings,
    output logic                       seq_trigger,
    output logic                       error,
    output host_ctrl_pkg::ctrl_state_e state
);
    import host_proto_pkg::*;
    import host_ctrl_pkg::*;

    logic      byte_valid;
    byte_t     byte_data;
    logic      cmd_mode;
    logic      instr_ack;
    logic      data_ack;
    token_t    token;
    logic      start;
    logic      step;
    logic      last;
    logic [1:0] length;
    logic [1:0] index;
    field_wr_t field_wr;

    // ==================================================
    // uart poll, then escape decode
    // ==================================================
    jtag_uart_reader jtag_uart_reader_i (
        .iCLK(iCLK), .iRST(iRST), .jtag_rddata(jtag_rddata), .jtag_wait(jtag_wait),
        .jtag_rdreq(jtag_rdreq), .byte_valid(byte_valid), .byte_data(byte_data)
    );

    escape_parser escape_parser_i (
        .iCLK(iCLK), .iRST(iRST), .byte_valid(byte_valid), .byte_data(byte_data),
        .cmd_mode(cmd_mode), .instr_ack(instr_ack), .data_ack(data_ack), .token(token)
    );

    // ==================================================
    // command control and register file
    // ==================================================
    link_fsm link_fsm_i (
        .iCLK(iCLK), .iRST(iRST), .token(token), .index(index), .last(last),
        .instr_ack(instr_ack), .data_ack(data_ack), .cmd_mode(cmd_mode),
        .start(start), .length(length), .step(step), .field_wr(field_wr),
        .seq_trigger(seq_trigger), .state(state)
    );

    field_byte_counter field_byte_counter_i (
        .iCLK(iCLK), .iRST(iRST), .start(start), .length(length), .step(step),
        .index(index), .last(last)
    );

    settings_regs settings_regs_i (
        .iCLK(iCLK), .iRST(iRST), .field_wr(field_wr), .settings(settings)
    );

    assign error = (state == ST_ERROR);

endmodule

// File: host_proto_pkg.sv
`include "host_link_config.svh"

package host_proto_pkg;

    typedef logic [`BYTE_W-1:0] byte_t;

    // opcodes accepted while idle
    typedef enum logic [`BYTE_W-1:0] {
        CMD_OFFSET_H = 8'h01,
        CMD_OFFSET_V = 8'h02,
        CMD_CYCLES   = 8'h03,
        CMD_TRIGGER  = 8'h04,
        CMD_GALVO_X  = 8'h05,
        CMD_GALVO_Y  = 8'h06
    } host_cmd_e;

    // byte that follows an escape
    typedef enum logic [`BYTE_W-1:0] {
        ESC_IDLE    = 8'h00,
        ESC_ACK     = 8'h01,
        ESC_LITERAL = `ESC_BYTE
    } esc_cmd_e;

    typedef enum logic [1:0] {
        INSTR_CMD,
        INSTR_IDLE,
        INSTR_ACK,
        INSTR_BAD
    } instr_e;

    typedef struct packed {
        logic      instr_pending;
        instr_e    instr;
        host_cmd_e cmd;
        logic      data_pending;
        byte_t     data;
    } token_t;

endpackage

// File: jtag_uart_reader.sv
`timescale 1ns/100ps

module jtag_uart_reader (
    input  logic                  iCLK,
    input  logic                  iRST,
    input  logic [31:0]           jtag_rddata,
    input  logic                  jtag_wait,
    output logic                  jtag_rdreq,
    output logic                  byte_valid,
    output host_proto_pkg::byte_t byte_data
);

    typedef enum logic {
        POLL_OFF,
        POLL_READ
    } poll_e;

    poll_e poll_state;
    logic  rd_done;

    // the data register is read back with zero latency once wait drops
    assign jtag_rdreq = (poll_state == POLL_READ);
    assign rd_done    = jtag_rdreq && !jtag_wait;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            poll_state <= POLL_OFF;
            byte_valid <= 1'b0;
        end else begin
            poll_state <= POLL_READ;
            // bit 15 flags a byte actually taken from the rx fifo
            byte_valid <= rd_done && jtag_rddata[15];
        end
    end

    always_ff @(posedge iCLK) begin
        byte_data <= jtag_rddata[7:0];
    end

    a_valid_after_read: assert property (@(posedge iCLK) disable iff (iRST)
        byte_valid |-> $past(jtag_rdreq && !jtag_wait))
        else $error("byte_valid without a completed read");

endmodule

// File: link_fsm.sv
`timescale 1ns/100ps

module link_fsm (
    input  logic                       iCLK,
    input  logic                       iRST,
    input  host_proto_pkg::token_t     token,
    input  logic [1:0]                 index,
    input  logic                       last,
    output logic                       instr_ack,
    output logic                       data_ack,
    output logic                       cmd_mode,
    output logic                       start,
    output logic [1:0]                 length,
    output logic                       step,
    output host_ctrl_pkg::field_wr_t   field_wr,
    output logic                       seq_trigger,
    output host_ctrl_pkg::ctrl_state_e state
);
    import host_proto_pkg::*;
    import host_ctrl_pkg::*;

    ctrl_state_e state_nxt;
    field_e      field_q;
    field_e      field_nxt;

    assign cmd_mode    = (state == ST_IDLE) || (state == ST_ERROR);
    assign seq_trigger = (state == ST_SEQ_TRIGGER);

    always_comb begin
        state_nxt = state;
        field_nxt = field_q;
        instr_ack = 1'b0;
        data_ack  = 1'b0;
        start     = 1'b0;
        length    = 2'd2;
        step      = 1'b0;
        field_wr  = '0;
        case (state)
            ST_IDLE, ST_ERROR: begin
                // data is meaningless here, drop it
                data_ack = token.data_pending;
                if (token.instr_pending) begin
                    instr_ack = 1'b1;
                    state_nxt = ST_ERROR;
                    if (token.instr == INSTR_IDLE) begin
                        state_nxt = ST_IDLE;
                    end else if (token.instr == INSTR_CMD) begin
                        start     = 1'b1;
                        state_nxt = ST_COLLECT;
                        case (token.cmd)
                            CMD_OFFSET_H: field_nxt = FLD_OFFSET_H;
                            CMD_OFFSET_V: field_nxt = FLD_OFFSET_V;
                            CMD_CYCLES:   field_nxt = FLD_CYCLES;
                            CMD_GALVO_X: begin
                                field_nxt = FLD_GALVO_X;
                                length    = 2'd3;
                            end
                            CMD_GALVO_Y: begin
                                field_nxt = FLD_GALVO_Y;
                                length    = 2'd3;
                            end
                            CMD_TRIGGER: begin
                                start     = 1'b0;
                                state_nxt = ST_SEQ_TRIGGER;
                            end
                            default: begin
                                start     = 1'b0;
                                state_nxt = ST_ERROR;
                            end
                        endcase
                    end
                end
            end
            ST_COLLECT: begin
                if (token.instr_pending) begin
                    instr_ack = 1'b1;
                    state_nxt = (token.instr == INSTR_IDLE) ? ST_IDLE : ST_ERROR;
                end else if (token.data_pending) begin
                    data_ack       = 1'b1;
                    step           = 1'b1;
                    field_wr.valid = 1'b1;
                    field_wr.field = field_q;
                    field_wr.index = index;
                    field_wr.data  = token.data;
                    if (last) begin
                        state_nxt = ST_WAIT_ACK;
                    end
                end
            end
            // single pulse, then the host has to acknowledge
            ST_SEQ_TRIGGER: state_nxt = ST_WAIT_ACK;
            ST_WAIT_ACK: begin
                if (token.instr_pending) begin
                    instr_ack = 1'b1;
                    state_nxt = (token.instr == INSTR_ACK) ? ST_IDLE : ST_ERROR;
                end else if (token.data_pending) begin
                    data_ack  = 1'b1;
                    state_nxt = ST_ERROR;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            state   <= ST_IDLE;
            field_q <= FLD_OFFSET_H;
        end else begin
            state   <= state_nxt;
            field_q <= field_nxt;
        end
    end

    a_trigger_pulse: assert property (@(posedge iCLK) disable iff (iRST)
        seq_trigger |=> !seq_trigger)
        else $error("sequencing trigger longer than one cycle");

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_host_link_decode \
    -f host_link_decode.f \
    -o sim_host_link_decode

out=$(./obj_dir/sim_host_link_decode)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: settings_regs.sv
`timescale 1ns/100ps
`include "host_link_config.svh"

module settings_regs (
    input  logic                     iCLK,
    input  logic                     iRST,
    input  host_ctrl_pkg::field_wr_t field_wr,
    output host_ctrl_pkg::settings_t settings
);
    import host_ctrl_pkg::*;

    // stored values before the offset clamp
    settings_t regs;

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            regs <= '0;
        end else if (field_wr.valid) begin
            case (field_wr.field)
                // byte 0 magnitude, byte 1 carries the sign in bit 0
                FLD_OFFSET_H: begin
                    if (field_wr.index == 2'd0) begin
                        regs.h_offset <= field_wr.data;
                    end else begin
                        regs.h_sign <= field_wr.data[0];
                    end
                end
                FLD_OFFSET_V: begin
                    if (field_wr.index == 2'd0) begin
                        regs.v_offset <= field_wr.data;
                    end else begin
                        regs.v_sign <= field_wr.data[0];
                    end
                end
                FLD_CYCLES:
                    regs.cycles[field_wr.index[0]*`BYTE_W +: `BYTE_W] <= field_wr.data;
                FLD_GALVO_X:
                    regs.galvo_x[field_wr.index*`BYTE_W +: `BYTE_W] <= field_wr.data;
                FLD_GALVO_Y:
                    regs.galvo_y[field_wr.index*`BYTE_W +: `BYTE_W] <= field_wr.data;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        settings = regs;
        if (regs.h_offset[`BYTE_W-1]) begin
            settings.h_offset = `BYTE_W'(`OFFSET_CLAMP);
        end
        if (regs.v_offset[`BYTE_W-1]) begin
            settings.v_offset = `BYTE_W'(`OFFSET_CLAMP);
        end
    end

endmodule

// File: tb_host_link_decode.sv
`timescale 1ns/100ps
`include "host_link_config.svh"

module tb_host_link_decode;
    import host_proto_pkg::*;
    import host_ctrl_pkg::*;

    logic        iCLK;
    logic        iRST;
    logic [31:0] jtag_rddata;
    logic        jtag_wait;
    logic        jtag_rdreq;
    settings_t   settings;
    logic        seq_trigger;
    logic        error;
    ctrl_state_e state;

    settings_t exp_set;
    string     test_name;
    int        checks;
    int        errors;
    int        tests;
    int        test_start_errors;
    int        trig_count;

    host_link_decode host_link_decode_i (
        .iCLK(iCLK), .iRST(iRST), .jtag_rddata(jtag_rddata), .jtag_wait(jtag_wait),
        .jtag_rdreq(jtag_rdreq), .settings(settings), .seq_trigger(seq_trigger),
        .error(error), .state(state)
    );

    initial begin
        iCLK = 1'b0;
        forever #50 iCLK = ~iCLK;
    end

    // trigger cycles, sampled mid-cycle
    always @(negedge iCLK) begin
        if (seq_trigger) begin
            trig_count = trig_count + 1;
        end
    end

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_state(input string what, input ctrl_state_e exp, input ctrl_state_e act);
        checks++;
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %s actual %s", test_name, what, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_settings(input string what, input settings_t exp, input settings_t act);
        checks++;
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // ==================================================
    // host side of the uart
    // ==================================================
    task automatic send_byte(input byte_t b, input bit stall);
        int n;
        int k;
        n = 0;
        while (!jtag_rdreq && n < 20) begin
            @(negedge iCLK);
            n++;
        end
        if (!jtag_rdreq) begin
            $display("%s: the DUT never raised its read request", test_name);
            errors++;
        end
        jtag_rddata = 32'h0000_8000 | {24'h0, b};
        if (stall) begin
            k = 1 + int'($urandom % 4);
            jtag_wait = 1'b1;
            repeat (k) @(negedge iCLK);
            jtag_wait = 1'b0;
        end
        @(negedge iCLK);
        jtag_rddata = 32'h0;
        // let the token drain before the next byte
        repeat (5) @(negedge iCLK);
    endtask

    // payload byte, with 0xFE sent doubled
    task automatic send_data(input byte_t b, input bit stall);
        if (b == `ESC_BYTE) begin
            send_byte(`ESC_BYTE, stall);
        end
        send_byte(b, stall);
    endtask

    task automatic send_escape(input byte_t code);
        send_byte(`ESC_BYTE, 1'b0);
        send_byte(code, 1'b0);
    endtask

    task automatic wait_state(input ctrl_state_e exp);
        int n;
        n = 0;
        while (state != exp && n < 50) begin
            @(negedge iCLK);
            n++;
        end
        if (state != exp) begin
            $display("%s: timed out waiting for state %s", test_name, exp.name());
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
        tests++;
    endtask

    task automatic finish_test();
        if (errors == test_start_errors) begin
            $display("[result] %s ok", test_name);
        end else begin
            $display("[result] %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_offsets();
        start_test("offsets");
        send_byte(8'h01, 1'b0);
        send_data(8'h05, 1'b0);
        send_data(8'h01, 1'b0);
        wait_state(ST_WAIT_ACK);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        exp_set.h_offset = 8'd5;
        exp_set.h_sign   = 1'b1;
        check_state("state after H", ST_IDLE, state);
        check_settings("settings after H", exp_set, settings);
        send_byte(8'h02, 1'b0);
        send_data(8'h9A, 1'b0);
        send_data(8'h00, 1'b0);
        wait_state(ST_WAIT_ACK);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        // 0x9A has its top bit set, so the output is clamped
        exp_set.v_offset = 8'd128;
        exp_set.v_sign   = 1'b0;
        check_settings("settings after V", exp_set, settings);
        finish_test();
    endtask

    task automatic test_cycles();
        start_test("display_cycles");
        send_byte(8'h03, 1'b0);
        send_data(8'h34, 1'b0);
        send_data(8'h12, 1'b0);
        wait_state(ST_WAIT_ACK);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        exp_set.cycles = 16'h1234;
        check_settings("settings", exp_set, settings);
        finish_test();
    endtask

    task automatic test_galvo();
        byte_t b [3];
        start_test("galvo");
        send_byte(8'h05, 1'b1);
        send_data(8'h11, 1'b1);
        send_data(8'hFE, 1'b1);
        send_data(8'h33, 1'b1);
        wait_state(ST_WAIT_ACK);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        exp_set.galvo_x = 24'h33FE11;
        check_settings("settings after X", exp_set, settings);
        send_byte(8'h06, 1'b0);
        for (int i = 0; i < 3; i++) begin
            b[i] = byte_t'($urandom);
            send_data(b[i], 1'b0);
        end
        wait_state(ST_WAIT_ACK);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        exp_set.galvo_y = {b[2], b[1], b[0]};
        check_settings("settings after Y", exp_set, settings);
        finish_test();
    endtask

    task automatic test_trigger();
        start_test("trigger");
        trig_count = 0;
        send_byte(8'h04, 1'b0);
        wait_state(ST_WAIT_ACK);
        check_count("trigger cycles", 1, trig_count);
        send_escape(ESC_ACK);
        wait_state(ST_IDLE);
        check_state("state after ack", ST_IDLE, state);
        check_settings("settings", exp_set, settings);
        finish_test();
    endtask

    task automatic test_errors();
        start_test("errors");
        send_byte(8'h80, 1'b0);
        wait_state(ST_ERROR);
        check_bit("error after unknown opcode", 1'b1, error);
        send_escape(ESC_IDLE);
        wait_state(ST_IDLE);
        check_bit("error after return to idle", 1'b0, error);
        check_settings("settings after unknown opcode", exp_set, settings);
        // extra data byte where the acknowledge belongs
        send_byte(8'h01, 1'b0);
        send_data(8'h07, 1'b0);
        send_data(8'h00, 1'b0);
        send_data(8'h55, 1'b0);
        wait_state(ST_ERROR);
        exp_set.h_offset = 8'd7;
        exp_set.h_sign   = 1'b0;
        check_state("state after missing ack", ST_ERROR, state);
        check_settings("settings after missing ack", exp_set, settings);
        send_escape(ESC_IDLE);
        wait_state(ST_IDLE);
        finish_test();
    endtask

    task automatic test_abort();
        start_test("abort");
        send_byte(8'h03, 1'b0);
        send_data(8'h78, 1'b0);
        wait_state(ST_COLLECT);
        send_escape(ESC_IDLE);
        wait_state(ST_IDLE);
        exp_set.cycles[7:0] = 8'h78;
        check_state("state", ST_IDLE, state);
        check_settings("settings", exp_set, settings);
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h26d0fc07));
        iRST        = 1'b1;
        jtag_rddata = 32'h0;
        jtag_wait   = 1'b0;
        exp_set     = '0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        trig_count  = 0;
        test_name   = "reset";
        repeat (4) @(posedge iCLK);
        @(negedge iCLK);
        iRST = 1'b0;
        check_bit("rdreq in first cycle", 1'b0, jtag_rdreq);
        check_state("state", ST_IDLE, state);
        check_settings("settings", exp_set, settings);
        check_bit("error", 1'b0, error);
        check_bit("seq_trigger", 1'b0, seq_trigger);

        test_offsets();
        test_cycles();
        test_galvo();
        test_trigger();
        test_errors();
        test_abort();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
